// File: verilog/isa_pkg.sv
package isa_pkg;

	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_REGIMM  = 6'b000001;
	localparam logic [5:0] OPC_J       = 6'b000010;
	localparam logic [5:0] OPC_JAL     = 6'b000011;
	localparam logic [5:0] OPC_BEQ     = 6'b000100;
	localparam logic [5:0] OPC_BNE     = 6'b000101;
	localparam logic [5:0] OPC_BLEZ    = 6'b000110;
	localparam logic [5:0] OPC_BGTZ    = 6'b000111;
	localparam logic [5:0] OPC_ADDI    = 6'b001000;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_SLTIU   = 6'b001011;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;
	localparam logic [5:0] OPC_LB      = 6'b100000;
	localparam logic [5:0] OPC_LH      = 6'b100001;
	localparam logic [5:0] OPC_LW      = 6'b100011;
	localparam logic [5:0] OPC_LBU     = 6'b100100;
	localparam logic [5:0] OPC_LHU     = 6'b100101;
	localparam logic [5:0] OPC_SB      = 6'b101000;
	localparam logic [5:0] OPC_SH      = 6'b101001;
	localparam logic [5:0] OPC_SW      = 6'b101011;

	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// regimm branches are selected by the rt field
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	localparam logic [4:0] REG_RA = 5'd31; // link register

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} inst_u;

endpackage

// File: verilog/pipe_pkg.sv
package pipe_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;

	// operation handed from decode to execute
	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_SLL, OP_SRL, OP_SRA,
		OP_SLLV, OP_SRLV, OP_SRAV,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_SLT, OP_SLTU,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
		OP_SB, OP_SH, OP_SW,
		OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
		OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
		OP_J, OP_JAL, OP_JR, OP_JALR
	} op_e;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, pipe_pkg::*;
(
	input  logic      rst,
	input  inst_u     inst_i,
	output op_e       op_o,
	output logic      re1_o,
	output logic      re2_o,
	output reg_addr_t raddr1_o,
	output reg_addr_t raddr2_o,
	output logic      wif_o,
	output reg_addr_t waddr_o,
	output word_t     imm_o
);
	word_t imm_zext;
	word_t imm_sext;

	assign raddr1_o = inst_i.r.rs;
	assign raddr2_o = inst_i.r.rt;
	assign imm_zext = {16'h0000, inst_i.i.imm16};
	assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};

	always_comb
	begin
		op_o = OP_NOP;
		if (!rst)
		begin
			case (inst_i.r.opcode)
				OPC_SPECIAL:
				begin
					case (inst_i.r.funct)
						FN_SLL:  op_o = OP_SLL;
						FN_SRL:  op_o = OP_SRL;
						FN_SRA:  op_o = OP_SRA;
						FN_SLLV: op_o = OP_SLLV;
						FN_SRLV: op_o = OP_SRLV;
						FN_SRAV: op_o = OP_SRAV;
						FN_JR:   op_o = OP_JR;
						FN_JALR: op_o = OP_JALR;
						FN_ADD:  op_o = OP_ADD;
						FN_ADDU: op_o = OP_ADDU;
						FN_SUB:  op_o = OP_SUB;
						FN_SUBU: op_o = OP_SUBU;
						FN_AND:  op_o = OP_AND;
						FN_OR:   op_o = OP_OR;
						FN_XOR:  op_o = OP_XOR;
						FN_NOR:  op_o = OP_NOR;
						FN_SLT:  op_o = OP_SLT;
						FN_SLTU: op_o = OP_SLTU;
						default: op_o = OP_NOP;
					endcase
				end
				OPC_REGIMM:
				begin
					case (inst_i.i.rt)
						RT_BLTZ:   op_o = OP_BLTZ;
						RT_BGEZ:   op_o = OP_BGEZ;
						RT_BLTZAL: op_o = OP_BLTZAL;
						RT_BGEZAL: op_o = OP_BGEZAL;
						default:   op_o = OP_NOP;
					endcase
				end
				OPC_J:     op_o = OP_J;
				OPC_JAL:   op_o = OP_JAL;
				OPC_BEQ:   op_o = OP_BEQ;
				OPC_BNE:   op_o = OP_BNE;
				OPC_BLEZ:  op_o = OP_BLEZ;
				OPC_BGTZ:  op_o = OP_BGTZ;
				OPC_ADDI:  op_o = OP_ADDI;
				OPC_ADDIU: op_o = OP_ADDIU;
				OPC_SLTI:  op_o = OP_SLTI;
				OPC_SLTIU: op_o = OP_SLTIU;
				OPC_ANDI:  op_o = OP_ANDI;
				OPC_ORI:   op_o = OP_ORI;
				OPC_XORI:  op_o = OP_XORI;
				OPC_LUI:   op_o = OP_LUI;
				OPC_LB:    op_o = OP_LB;
				OPC_LH:    op_o = OP_LH;
				OPC_LW:    op_o = OP_LW;
				OPC_LBU:   op_o = OP_LBU;
				OPC_LHU:   op_o = OP_LHU;
				OPC_SB:    op_o = OP_SB;
				OPC_SH:    op_o = OP_SH;
				OPC_SW:    op_o = OP_SW;
				default:   op_o = OP_NOP; // illegal word
			endcase
		end
	end

	// read enables, write-back target and immediate follow from the operation
	always_comb
	begin
		re1_o = 1'b0;
		re2_o = 1'b0;
		wif_o = 1'b0;
		waddr_o = '0;
		imm_o = '0;
		case (op_o)
			OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLLV, OP_SRLV, OP_SRAV,
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU:
			begin
				re1_o = 1'b1;
				re2_o = 1'b1;
				wif_o = 1'b1;
				waddr_o = inst_i.r.rd;
			end
			OP_SLL, OP_SRL, OP_SRA:
			begin
				re2_o = 1'b1;
				wif_o = 1'b1;
				waddr_o = inst_i.r.rd;
				imm_o = {27'd0, inst_i.r.shamt}; // shift amount on operand 1
			end
			OP_ANDI, OP_ORI, OP_XORI:
			begin
				re1_o = 1'b1;
				wif_o = 1'b1;
				waddr_o = inst_i.i.rt;
				imm_o = imm_zext;
			end
			OP_LUI:
			begin
				wif_o = 1'b1;
				waddr_o = inst_i.i.rt;
				imm_o = {inst_i.i.imm16, 16'h0000};
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW:
			begin
				re1_o = 1'b1;
				wif_o = 1'b1;
				waddr_o = inst_i.i.rt;
				imm_o = imm_sext; // loads carry the address offset
			end
			OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE:
			begin
				re1_o = 1'b1;
				re2_o = 1'b1;
			end
			OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_BGEZ, OP_JR:
				re1_o = 1'b1;
			OP_BLTZAL, OP_BGEZAL:
			begin
				re1_o = 1'b1;
				wif_o = 1'b1;
				waddr_o = REG_RA;
			end
			OP_JAL:
			begin
				wif_o = 1'b1;
				waddr_o = REG_RA;
			end
			OP_JALR:
			begin
				re1_o = 1'b1;
				wif_o = 1'b1;
				waddr_o = inst_i.r.rd;
			end
			default:
			begin
			end
		endcase
	end

endmodule

// File: verilog/operand_hazard.sv
`timescale 1ns/1ps

module operand_hazard import pipe_pkg::*;
(
	input  logic      rst,
	input  logic      re1_i,
	input  logic      re2_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	input  word_t     imm_i,
	input  word_t     rf_data1_i,
	input  word_t     rf_data2_i,
	input  op_e       ex_op_i,
	input  logic      ex_wif_i,
	input  reg_addr_t ex_waddr_i,
	input  word_t     ex_data_i,
	input  logic      mem_wif_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_data_i,
	output word_t     data1_o,
	output word_t     data2_o,
	output logic      stall_o
);
	logic load_in_ex;
	logic load_use;

	// operand select with ex over mem over the register file
	function automatic word_t pick(input logic re, input reg_addr_t raddr, input word_t rf_data);
		word_t val;
		if (!re)
			val = imm_i;
		else if (ex_wif_i && raddr != '0 && raddr == ex_waddr_i)
			val = ex_data_i;
		else if (mem_wif_i && raddr != '0 && raddr == mem_waddr_i)
			val = mem_data_i;
		else
			val = rf_data;
		return val;
	endfunction

	assign load_in_ex = ex_op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
	assign load_use = (re1_i && raddr1_i != '0 && raddr1_i == ex_waddr_i) ||
		(re2_i && raddr2_i != '0 && raddr2_i == ex_waddr_i);
	assign stall_o = !rst && load_in_ex && load_use; // load result not ready until mem

	always_comb
	begin
		data1_o = '0;
		data2_o = '0;
		if (!rst)
		begin
			data1_o = pick(re1_i, raddr1_i, rf_data1_i);
			data2_o = pick(re2_i, raddr2_i, rf_data2_i);
		end
	end

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve import isa_pkg::*, pipe_pkg::*;
(
	input  logic  rst,
	input  op_e   op_i,
	input  inst_u inst_i,
	input  word_t pc_i,
	input  word_t data1_i,
	input  word_t data2_i,
	input  logic  stall_i,
	output logic  branch_flag_o,
	output word_t branch_target_o,
	output word_t link_addr_o
);
	word_t pc_plus4;
	word_t pc_plus8;
	word_t br_target;
	word_t jmp_target;
	word_t target;
	logic  cond;
	logic  taken;
	logic  d1_neg;
	logic  d1_zero;

	assign pc_plus4 = pc_i + 32'd4;
	assign pc_plus8 = pc_i + 32'd8;
	assign br_target = pc_plus4 + {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};
	assign jmp_target = {pc_plus4[31:28], inst_i.j.target26, 2'b00};
	assign d1_neg = data1_i[31];
	assign d1_zero = data1_i == '0;

	always_comb
	begin
		cond = 1'b0;
		target = br_target;
		case (op_i)
			OP_BEQ:             cond = data1_i == data2_i;
			OP_BNE:             cond = data1_i != data2_i;
			OP_BGTZ:            cond = !d1_neg && !d1_zero;
			OP_BLEZ:            cond = d1_neg || d1_zero;
			OP_BLTZ, OP_BLTZAL: cond = d1_neg;
			OP_BGEZ, OP_BGEZAL: cond = !d1_neg;
			OP_J, OP_JAL:
			begin
				cond = 1'b1;
				target = jmp_target;
			end
			OP_JR, OP_JALR:
			begin
				cond = 1'b1;
				target = data1_i; // register operand after forwarding
			end
			default:            cond = 1'b0;
		endcase
	end

	assign taken = cond && !stall_i && !rst; // stalled operands may be stale
	assign branch_flag_o = taken;
	assign branch_target_o = taken ? target : '0;
	// link is written whether or not the branch goes
	assign link_addr_o = (op_i inside {OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL}) ? pc_plus8 : '0;

endmodule

// File: verilog/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      stall_i,
	input  op_e       op_i,
	input  logic      wif_i,
	input  reg_addr_t waddr_i,
	input  word_t     data1_i,
	input  word_t     data2_i,
	input  word_t     link_addr_i,
	output op_e       id_ex_op_o,
	output logic      id_ex_wif_o,
	output reg_addr_t id_ex_waddr_o,
	output word_t     id_ex_data1_o,
	output word_t     id_ex_data2_o,
	output word_t     id_ex_link_addr_o
);

	always_ff @(posedge clk)
	begin
		if (rst || stall_i)
		begin
			id_ex_op_o <= OP_NOP; // bubble
			id_ex_wif_o <= 1'b0;
			id_ex_waddr_o <= '0;
			id_ex_data1_o <= '0;
			id_ex_data2_o <= '0;
			id_ex_link_addr_o <= '0;
		end
		else
		begin
			id_ex_op_o <= op_i;
			id_ex_wif_o <= wif_i;
			id_ex_waddr_o <= waddr_i;
			id_ex_data1_o <= data1_i;
			id_ex_data2_o <= data2_i;
			id_ex_link_addr_o <= link_addr_i;
		end
	end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  word_t     inst_i,
	input  word_t     pc_i,
	input  word_t     rf_data1_i,
	input  word_t     rf_data2_i,
	input  op_e       ex_op_i,
	input  logic      ex_wif_i,
	input  reg_addr_t ex_waddr_i,
	input  word_t     ex_data_i,
	input  logic      mem_wif_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_data_i,
	output logic      rf_re1_o,
	output reg_addr_t rf_raddr1_o,
	output logic      rf_re2_o,
	output reg_addr_t rf_raddr2_o,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output logic      stall_o,
	output op_e       id_ex_op_o,
	output logic      id_ex_wif_o,
	output reg_addr_t id_ex_waddr_o,
	output word_t     id_ex_data1_o,
	output word_t     id_ex_data2_o,
	output word_t     id_ex_link_addr_o
);
	op_e       op;
	logic      wif;
	reg_addr_t waddr;
	word_t     imm;
	word_t     data1;
	word_t     data2;
	word_t     link_addr;

	inst_decoder u_dec (
		.rst      (rst),
		.inst_i   (inst_i),
		.op_o     (op),
		.re1_o    (rf_re1_o),
		.re2_o    (rf_re2_o),
		.raddr1_o (rf_raddr1_o),
		.raddr2_o (rf_raddr2_o),
		.wif_o    (wif),
		.waddr_o  (waddr),
		.imm_o    (imm)
	);

	operand_hazard u_hz (
		.rst         (rst),
		.re1_i       (rf_re1_o),
		.re2_i       (rf_re2_o),
		.raddr1_i    (rf_raddr1_o),
		.raddr2_i    (rf_raddr2_o),
		.imm_i       (imm),
		.rf_data1_i  (rf_data1_i),
		.rf_data2_i  (rf_data2_i),
		.ex_op_i     (ex_op_i),
		.ex_wif_i    (ex_wif_i),
		.ex_waddr_i  (ex_waddr_i),
		.ex_data_i   (ex_data_i),
		.mem_wif_i   (mem_wif_i),
		.mem_waddr_i (mem_waddr_i),
		.mem_data_i  (mem_data_i),
		.data1_o     (data1),
		.data2_o     (data2),
		.stall_o     (stall_o)
	);

	branch_resolve u_br (
		.rst             (rst),
		.op_i            (op),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.data1_i         (data1), // forwarded operands
		.data2_i         (data2),
		.stall_i         (stall_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr)
	);

	id_ex_reg u_idex (
		.clk               (clk),
		.rst               (rst),
		.stall_i           (stall_o),
		.op_i              (op),
		.wif_i             (wif),
		.waddr_i           (waddr),
		.data1_i           (data1),
		.data2_i           (data2),
		.link_addr_i       (link_addr),
		.id_ex_op_o        (id_ex_op_o),
		.id_ex_wif_o       (id_ex_wif_o),
		.id_ex_waddr_o     (id_ex_waddr_o),
		.id_ex_data1_o     (id_ex_data1_o),
		.id_ex_data2_o     (id_ex_data2_o),
		.id_ex_link_addr_o (id_ex_link_addr_o)
	);

endmodule

// File: verif/decode_stage_checker.sv
`timescale 1ns/1ps

module decode_stage_checker import pipe_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      stall_i,
	input logic      branch_flag_i,
	input op_e       id_ex_op_i,
	input logic      id_ex_wif_i,
	input reg_addr_t id_ex_waddr_i,
	input word_t     id_ex_data1_i,
	input word_t     id_ex_data2_i,
	input word_t     id_ex_link_addr_i
);
	int unsigned fail_cnt = 0;
	logic bubble;

	assign bubble = id_ex_op_i == OP_NOP && !id_ex_wif_i && id_ex_waddr_i == '0 &&
		id_ex_data1_i == '0 && id_ex_data2_i == '0 && id_ex_link_addr_i == '0;

	stall_bubble: assert property (@(posedge clk) stall_i |=> bubble)
	else
	begin
		fail_cnt++;
		$error("ID/EX register did not hold a bubble after a stall");
	end

	reset_bubble: assert property (@(posedge clk) rst |=> bubble)
	else
	begin
		fail_cnt++;
		$error("ID/EX register did not hold a bubble after reset");
	end

	// a stalled branch must not redirect fetch
	no_branch_in_stall: assert property (@(posedge clk) !(stall_i && branch_flag_i))
	else
	begin
		fail_cnt++;
		$error("branch flag raised while the stage was stalled");
	end

endmodule

bind id_ex_reg decode_stage_checker u_chk (
	.clk               (clk),
	.rst               (rst),
	.stall_i           (stall_i),
	.branch_flag_i     (decode_stage.branch_flag_o),
	.id_ex_op_i        (id_ex_op_o),
	.id_ex_wif_i       (id_ex_wif_o),
	.id_ex_waddr_i     (id_ex_waddr_o),
	.id_ex_data1_i     (id_ex_data1_o),
	.id_ex_data2_i     (id_ex_data2_o),
	.id_ex_link_addr_i (id_ex_link_addr_o)
);

// File: verif/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb import isa_pkg::*, pipe_pkg::*;
();
	localparam int NUM_TESTS = 400;
	localparam int MAX_CYCLES = NUM_TESTS * 2 + 20;
	localparam logic [31:0] SEED = 32'h7dc2bb20;
	localparam int TAB_LEN = 45;

	typedef struct packed {
		logic [5:0] opc;
		logic [5:0] sel; // funct for special, rt for regimm
		op_e        op;
	} tab_t;

	typedef struct packed {
		logic      re1;
		logic      re2;
		reg_addr_t raddr1;
		reg_addr_t raddr2;
		logic      branch;
		word_t     target;
		logic      stall;
		op_e       op;
		logic      wif;
		reg_addr_t waddr;
		word_t     data1;
		word_t     data2;
		word_t     link;
	} exp_t;

	localparam tab_t TAB [TAB_LEN] = '{
		'{OPC_SPECIAL, FN_SLL, OP_SLL}, '{OPC_SPECIAL, FN_SRL, OP_SRL},
		'{OPC_SPECIAL, FN_SRA, OP_SRA}, '{OPC_SPECIAL, FN_SLLV, OP_SLLV},
		'{OPC_SPECIAL, FN_SRLV, OP_SRLV}, '{OPC_SPECIAL, FN_SRAV, OP_SRAV},
		'{OPC_SPECIAL, FN_JR, OP_JR}, '{OPC_SPECIAL, FN_JALR, OP_JALR},
		'{OPC_SPECIAL, FN_ADD, OP_ADD}, '{OPC_SPECIAL, FN_ADDU, OP_ADDU},
		'{OPC_SPECIAL, FN_SUB, OP_SUB}, '{OPC_SPECIAL, FN_SUBU, OP_SUBU},
		'{OPC_SPECIAL, FN_AND, OP_AND}, '{OPC_SPECIAL, FN_OR, OP_OR},
		'{OPC_SPECIAL, FN_XOR, OP_XOR}, '{OPC_SPECIAL, FN_NOR, OP_NOR},
		'{OPC_SPECIAL, FN_SLT, OP_SLT}, '{OPC_SPECIAL, FN_SLTU, OP_SLTU},
		'{OPC_REGIMM, {1'b0, RT_BLTZ}, OP_BLTZ}, '{OPC_REGIMM, {1'b0, RT_BGEZ}, OP_BGEZ},
		'{OPC_REGIMM, {1'b0, RT_BLTZAL}, OP_BLTZAL}, '{OPC_REGIMM, {1'b0, RT_BGEZAL}, OP_BGEZAL},
		'{OPC_J, 6'd0, OP_J}, '{OPC_JAL, 6'd0, OP_JAL}, '{OPC_BEQ, 6'd0, OP_BEQ},
		'{OPC_BNE, 6'd0, OP_BNE}, '{OPC_BLEZ, 6'd0, OP_BLEZ}, '{OPC_BGTZ, 6'd0, OP_BGTZ},
		'{OPC_ADDI, 6'd0, OP_ADDI}, '{OPC_ADDIU, 6'd0, OP_ADDIU}, '{OPC_SLTI, 6'd0, OP_SLTI},
		'{OPC_SLTIU, 6'd0, OP_SLTIU}, '{OPC_ANDI, 6'd0, OP_ANDI}, '{OPC_ORI, 6'd0, OP_ORI},
		'{OPC_XORI, 6'd0, OP_XORI}, '{OPC_LUI, 6'd0, OP_LUI}, '{OPC_LB, 6'd0, OP_LB},
		'{OPC_LH, 6'd0, OP_LH}, '{OPC_LW, 6'd0, OP_LW}, '{OPC_LBU, 6'd0, OP_LBU},
		'{OPC_LHU, 6'd0, OP_LHU}, '{OPC_SB, 6'd0, OP_SB}, '{OPC_SH, 6'd0, OP_SH},
		'{OPC_SW, 6'd0, OP_SW},
		'{6'h3f, 6'd0, OP_NOP} // illegal word
	};

	logic clk;
	logic rst;
	word_t inst_i, pc_i, rf_data1_i, rf_data2_i, ex_data_i, mem_data_i;
	op_e ex_op_i;
	logic ex_wif_i, mem_wif_i;
	reg_addr_t ex_waddr_i, mem_waddr_i;
	logic rf_re1_o, rf_re2_o, branch_flag_o, stall_o, id_ex_wif_o;
	reg_addr_t rf_raddr1_o, rf_raddr2_o, id_ex_waddr_o;
	word_t branch_target_o, id_ex_data1_o, id_ex_data2_o, id_ex_link_addr_o;
	op_e id_ex_op_o;

	logic [31:0] lfsr;
	op_e cur_op;
	exp_t exp_cur, exp_prev;
	bit prev_valid;
	int unsigned comb_errs, reg_errs, cycles;

	decode_stage i_dut (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// biased toward the current source registers so forwarding gets exercised
	function automatic reg_addr_t pick_addr();
		logic [1:0] s;
		s = 2'(rand_bits(2));
		case (s)
			2'd0: return inst_i[25:21];
			2'd1: return inst_i[20:16];
			2'd2: return 5'd0;
			default: return 5'(rand_bits(5));
		endcase
	endfunction

	function automatic word_t fwd(input logic re, input reg_addr_t ra, input word_t rf,
		input word_t imm);
		if (!re)
			return imm;
		if (ex_wif_i && ra != 5'd0 && ra == ex_waddr_i)
			return ex_data_i;
		if (mem_wif_i && ra != 5'd0 && ra == mem_waddr_i)
			return mem_data_i;
		return rf;
	endfunction

	// expected outputs for the inputs now applied; op..link are the next ID/EX values
	function automatic exp_t expected();
		exp_t e;
		op_e op;
		word_t imm, d1, d2, p4, tgt;
		logic taken;
		logic [15:0] i16;
		i16 = inst_i[15:0];
		op = rst ? OP_NOP : cur_op;
		e = '0;
		imm = '0;
		e.raddr1 = inst_i[25:21];
		e.raddr2 = inst_i[20:16];
		e.re1 = !(op inside {OP_NOP, OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_J, OP_JAL});
		e.re2 = op inside {OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_SLLV,
			OP_SRLV, OP_SRAV, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
			OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE};
		e.wif = !(op inside {OP_NOP, OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
			OP_BLTZ, OP_BGEZ, OP_J, OP_JR});
		if (!e.wif)
			e.waddr = 5'd0;
		else if (op inside {OP_JAL, OP_BLTZAL, OP_BGEZAL})
			e.waddr = 5'd31;
		else if (inst_i[31:26] == 6'd0)
			e.waddr = inst_i[15:11]; // rd
		else
			e.waddr = inst_i[20:16];
		if (op inside {OP_ANDI, OP_ORI, OP_XORI})
			imm = {16'd0, i16};
		else if (op == OP_LUI)
			imm = {i16, 16'd0};
		else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LB, OP_LBU, OP_LH,
			OP_LHU, OP_LW})
			imm = {{16{i16[15]}}, i16};
		else if (op inside {OP_SLL, OP_SRL, OP_SRA})
			imm = {27'd0, inst_i[10:6]};
		d1 = rst ? '0 : fwd(e.re1, e.raddr1, rf_data1_i, imm);
		d2 = rst ? '0 : fwd(e.re2, e.raddr2, rf_data2_i, imm);
		e.stall = !rst && (ex_op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) &&
			((e.re1 && e.raddr1 != 0 && e.raddr1 == ex_waddr_i) ||
			(e.re2 && e.raddr2 != 0 && e.raddr2 == ex_waddr_i));
		p4 = pc_i + 32'd4;
		tgt = p4 + {{14{i16[15]}}, i16, 2'b00};
		taken = 1'b0;
		case (op)
			OP_BEQ: taken = d1 == d2;
			OP_BNE: taken = d1 != d2;
			OP_BGTZ: taken = $signed(d1) > 0;
			OP_BLEZ: taken = $signed(d1) <= 0;
			OP_BLTZ, OP_BLTZAL: taken = $signed(d1) < 0;
			OP_BGEZ, OP_BGEZAL: taken = $signed(d1) >= 0;
			OP_J, OP_JAL:
			begin
				taken = 1'b1;
				tgt = {p4[31:28], inst_i[25:0], 2'b00};
			end
			OP_JR, OP_JALR:
			begin
				taken = 1'b1;
				tgt = d1;
			end
			default: taken = 1'b0;
		endcase
		e.branch = taken && !e.stall;
		e.target = e.branch ? tgt : '0;
		e.link = (op inside {OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL}) ? pc_i + 32'd8 : '0;
		e.op = op;
		e.data1 = d1;
		e.data2 = d2;
		if (rst || e.stall)
		begin
			e.op = OP_NOP; // bubble
			e.wif = 1'b0;
			e.waddr = '0;
			e.data1 = '0;
			e.data2 = '0;
			e.link = '0;
		end
		return e;
	endfunction

	task automatic drive_inputs();
		int j;
		if (!stall_o) // fetch holds inst and pc during a stall
		begin
			j = int'(rand_bits(6)) % TAB_LEN;
			cur_op = TAB[j].op;
			inst_i = {TAB[j].opc, 26'(rand_bits(26))};
			if (TAB[j].opc == OPC_SPECIAL)
				inst_i[5:0] = TAB[j].sel;
			else if (TAB[j].opc == OPC_REGIMM)
				inst_i[20:16] = TAB[j].sel[4:0];
			pc_i = rand_bits(30) << 2;
		end
		rf_data1_i = rand_bits(32);
		if (rand_bits(3) == 0)
			rf_data1_i = '0;
		rf_data2_i = (rand_bits(2) == 0) ? rf_data1_i : rand_bits(32);
		j = int'(rand_bits(6)) % TAB_LEN;
		ex_op_i = (rand_bits(2) == 0) ? OP_LW : TAB[j].op;
		ex_wif_i = 1'(rand_bits(1));
		ex_waddr_i = pick_addr();
		ex_data_i = rand_bits(32);
		mem_wif_i = 1'(rand_bits(1));
		mem_waddr_i = pick_addr();
		mem_data_i = rand_bits(32);
	endtask

	task automatic check(input string name, input logic [31:0] want, input logic [31:0] got,
		input bit is_reg);
		assert (got === want)
		else
		begin
			if (is_reg)
				reg_errs++;
			else
				comb_errs++;
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, want, got);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// inputs only move on the falling edge, so both sets are steady here
	initial
	begin
		prev_valid = 0;
		forever
		begin
			@(posedge clk);
			check("rf_re1_o", exp_cur.re1, rf_re1_o, 0);
			check("rf_raddr1_o", exp_cur.raddr1, rf_raddr1_o, 0);
			check("rf_re2_o", exp_cur.re2, rf_re2_o, 0);
			check("rf_raddr2_o", exp_cur.raddr2, rf_raddr2_o, 0);
			check("branch_flag_o", exp_cur.branch, branch_flag_o, 0);
			check("branch_target_o", exp_cur.target, branch_target_o, 0);
			check("stall_o", exp_cur.stall, stall_o, 0);
			if (prev_valid)
			begin
				check("id_ex_op_o", exp_prev.op, id_ex_op_o, 1);
				check("id_ex_wif_o", exp_prev.wif, id_ex_wif_o, 1);
				check("id_ex_waddr_o", exp_prev.waddr, id_ex_waddr_o, 1);
				check("id_ex_data1_o", exp_prev.data1, id_ex_data1_o, 1);
				check("id_ex_data2_o", exp_prev.data2, id_ex_data2_o, 1);
				check("id_ex_link_addr_o", exp_prev.link, id_ex_link_addr_o, 1);
			end
			exp_prev = exp_cur;
			prev_valid = 1;
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		int unsigned chk_errs;
		lfsr = SEED;
		rst = 1'b1;
		inst_i = '0;
		pc_i = '0;
		rf_data1_i = '0;
		rf_data2_i = '0;
		ex_op_i = OP_NOP;
		ex_wif_i = 1'b0;
		ex_waddr_i = '0;
		ex_data_i = '0;
		mem_wif_i = 1'b0;
		mem_waddr_i = '0;
		mem_data_i = '0;
		cur_op = OP_NOP;
		comb_errs = 0;
		reg_errs = 0;
		exp_cur = expected();
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			@(negedge clk);
			if (i == 3)
				rst = 1'b0; // four rising edges seen in reset
			drive_inputs();
			exp_cur = expected();
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		chk_errs = i_dut.u_idex.u_chk.fail_cnt;
		$display("errors: combinational %0d, id_ex %0d, checker %0d",
			comb_errs, reg_errs, chk_errs);
		if (comb_errs == 0 && reg_errs == 0 && chk_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: decode_stage.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/operand_hazard.sv
verilog/branch_resolve.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
verif/decode_stage_checker.sv
verif/decode_stage_tb.sv
